/* Bender.yml */
package:
  name: racer_video

sources:
  - include_dirs:
      - logic
    files:
      - logic/racer_video_pkg.sv
      - logic/cpu_bus_if.sv
      - logic/video_timing_if.sv
      - logic/video_timing.sv
      - logic/road_layer.sv
      - logic/palette_mixer.sv
      - logic/racer_video.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/racer_video_asserts.sv
      - test/racer_video_tb.sv

/* flist.f */
+incdir+logic
logic/racer_video_pkg.sv
logic/cpu_bus_if.sv
logic/video_timing_if.sv
logic/video_timing.sv
logic/road_layer.sv
logic/palette_mixer.sv
logic/racer_video.sv
test/racer_video_asserts.sv
test/racer_video_tb.sv

/* logic/cpu_bus_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu write and read address bus shared
// by the road table and the palette
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

    // word address, write data, byte strobes
    racer_video_pkg::cpu_addr_t addr;
    racer_video_pkg::cpu_word_t dout;
    racer_video_pkg::byte_en_t  dswn;

    modport host (
        output addr,
        output dout,
        output dswn
    );

    // each memory has its own chip select outside the bus
    modport dev (
        input addr,
        input dout,
        input dswn
    );

endinterface

`default_nettype wire

/* logic/palette_mixer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// palette ram with cpu port
// road over sky priority, blanking delay
// and rgb output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "racer_video_settings.svh"

module palette_mixer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic                       pal_cs,
    cpu_bus_if.dev                     cpu,
    video_timing_if.sink               tim,
    input  racer_video_pkg::pal_idx_t  rd_pxl,
    output racer_video_pkg::cpu_word_t pal_dout,
    output logic                       lhbl,
    output logic                       lvbl,
    output logic [4:0]                 red,
    output logic [4:0]                 green,
    output logic [4:0]                 blue
);

    racer_video_pkg::cpu_word_t pal_ram [`RV_PAL_DEPTH];
    racer_video_pkg::pal_idx_t  cpu_idx;
    racer_video_pkg::pal_idx_t  sky_idx;
    racer_video_pkg::pal_idx_t  pxl_idx;
    racer_video_pkg::rgb555_t   colour;

    // first stage, aligned with rd_pxl
    logic [1:0] sky_band;
    logic       lhbl_d1;
    logic       lvbl_d1;

    // palette mirrors over the upper half of the cpu window
    assign cpu_idx = cpu.addr[3:0];

    always_ff @(posedge clk) begin
        if (pal_cs && !cpu.dswn[0]) begin
            pal_ram[cpu_idx][7:0] <= cpu.dout[7:0];
        end
        if (pal_cs && !cpu.dswn[1]) begin
            pal_ram[cpu_idx][15:8] <= cpu.dout[15:8];
        end
        pal_dout <= pal_ram[cpu_idx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sky_band <= '0;
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
        end else if (pxl_cen) begin
            sky_band <= tim.vdump[4:3];
            lhbl_d1  <= tim.pre_lhbl;
            lvbl_d1  <= tim.pre_lvbl;
        end
    end

    // road wins over sky
    assign sky_idx = {2'b00, sky_band};
    assign pxl_idx = (rd_pxl != '0) ? rd_pxl : sky_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            colour <= '0;
            lhbl   <= 1'b0;
            lvbl   <= 1'b0;
        end else if (pxl_cen) begin
            lhbl   <= lhbl_d1;
            lvbl   <= lvbl_d1;
            colour <= (lhbl_d1 && lvbl_d1) ? pal_ram[pxl_idx][14:0] : '0;
        end
    end

    assign red   = colour[4:0];
    assign green = colour[9:5];
    assign blue  = colour[14:10];

endmodule

`default_nettype wire

/* logic/racer_video.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video subsystem top level
// timing, road layer and colour mixer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module racer_video (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    // cpu bus
    input  logic                       road_cs,
    input  logic                       pal_cs,
    input  racer_video_pkg::cpu_addr_t cpu_addr,
    input  racer_video_pkg::cpu_word_t cpu_dout,
    input  racer_video_pkg::byte_en_t  cpu_dswn,
    output racer_video_pkg::cpu_word_t road_dout,
    output racer_video_pkg::cpu_word_t pal_dout,
    // video out
    output logic                       hs,
    output logic                       vs,
    output logic                       lhbl,
    output logic                       lvbl,
    output logic                       vint,
    output logic                       line_intn,
    output racer_video_pkg::hpos_t     hdump,
    output racer_video_pkg::vpos_t     vdump,
    output logic [4:0]                 red,
    output logic [4:0]                 green,
    output logic [4:0]                 blue
);

    cpu_bus_if      u_cpu ();
    video_timing_if u_tim ();

    racer_video_pkg::pal_idx_t rd_pxl;

    assign u_cpu.addr = cpu_addr;
    assign u_cpu.dout = cpu_dout;
    assign u_cpu.dswn = cpu_dswn;

    assign hdump = u_tim.hdump;
    assign vdump = u_tim.vdump;

    video_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .tim       ( u_tim.src ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .vint      ( vint      ),
        .line_intn ( line_intn )
    );

    road_layer u_road (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .pxl_cen   ( pxl_cen    ),
        .road_cs   ( road_cs    ),
        .cpu       ( u_cpu.dev  ),
        .tim       ( u_tim.sink ),
        .road_dout ( road_dout  ),
        .rd_pxl    ( rd_pxl     )
    );

    palette_mixer u_colmix (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .pxl_cen   ( pxl_cen    ),
        .pal_cs    ( pal_cs     ),
        .cpu       ( u_cpu.dev  ),
        .tim       ( u_tim.sink ),
        .rd_pxl    ( rd_pxl     ),
        .pal_dout  ( pal_dout   ),
        .lhbl      ( lhbl       ),
        .lvbl      ( lvbl       ),
        .red       ( red        ),
        .green     ( green      ),
        .blue      ( blue       )
    );

endmodule

`default_nettype wire

/* logic/racer_video_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector types shared by the video blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package racer_video_pkg;

    // raster counters
    typedef logic [7:0] hpos_t;
    typedef logic [7:0] vpos_t;

    // palette index, 0 means no road pixel
    typedef logic [3:0] pal_idx_t;

    // red in [4:0], green in [9:5], blue in [14:10]
    typedef logic [14:0] rgb555_t;

    // cpu side
    typedef logic [15:0] cpu_word_t;
    typedef logic [4:0] cpu_addr_t;

    // active low, bit 1 is the upper byte
    typedef logic [1:0] byte_en_t;

endpackage

`default_nettype wire

/* logic/racer_video_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster sizes and sync windows
// interrupt spacing and memory depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RACER_VIDEO_SETTINGS_SVH
`define RACER_VIDEO_SETTINGS_SVH

// horizontal raster, in pixels
`define RV_H_TOTAL    64
`define RV_H_VIS      48
`define RV_HS_START   52
`define RV_HS_END     56

// vertical raster, in lines
`define RV_V_TOTAL    40
`define RV_V_VIS      32
`define RV_VS_START   34
`define RV_VS_END     36

`define RV_IRQ_STEP   8
`define RV_ROAD_DEPTH 32
`define RV_PAL_DEPTH  16

`endif

/* logic/road_layer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// road table ram with cpu port
// per pixel road index generation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "racer_video_settings.svh"

module road_layer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic                       road_cs,
    cpu_bus_if.dev                     cpu,
    video_timing_if.sink               tim,
    output racer_video_pkg::cpu_word_t road_dout,
    output racer_video_pkg::pal_idx_t  rd_pxl
);

    localparam racer_video_pkg::pal_idx_t EDGE_IDX = 4'd10;
    localparam racer_video_pkg::pal_idx_t EVEN_IDX = 4'd8;
    localparam racer_video_pkg::pal_idx_t ODD_IDX  = 4'd9;
    // kerb width in pixels
    localparam logic signed [9:0] EDGE_W = 10'sd2;

    racer_video_pkg::cpu_word_t road_ram [`RV_ROAD_DEPTH];
    racer_video_pkg::cpu_addr_t line_addr;
    racer_video_pkg::cpu_word_t line_word;
    racer_video_pkg::pal_idx_t  pxl_nxt;

    logic signed [9:0] centre;
    logic signed [9:0] half_w;
    logic signed [9:0] hpos;
    logic signed [9:0] left;
    logic signed [9:0] right;
    logic              on_road;
    logic              on_edge;

    // cpu side, byte lanes
    always_ff @(posedge clk) begin
        if (road_cs && !cpu.dswn[0]) begin
            road_ram[cpu.addr][7:0] <= cpu.dout[7:0];
        end
        if (road_cs && !cpu.dswn[1]) begin
            road_ram[cpu.addr][15:8] <= cpu.dout[15:8];
        end
        road_dout <= road_ram[cpu.addr];
    end

    // video side, one word per visible line
    assign line_addr = tim.vdump[4:0];
    assign line_word = road_ram[line_addr];

    assign centre = $signed({2'b00, line_word[7:0]});
    assign half_w = $signed({2'b00, line_word[15:8]});
    assign hpos   = $signed({2'b00, tim.hdump});
    assign left   = centre - half_w;
    assign right  = centre + half_w;

    assign on_road = (hpos >= left) && (hpos < right);
    assign on_edge = (hpos < left + EDGE_W) || (hpos >= right - EDGE_W);

    always_comb begin
        if (!on_road) begin
            pxl_nxt = '0;
        end else if (on_edge) begin
            pxl_nxt = EDGE_IDX;
        end else begin
            // stripes alternate every two lines
            pxl_nxt = tim.vdump[1] ? ODD_IDX : EVEN_IDX;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pxl <= '0;
        end else if (pxl_cen) begin
            rd_pxl <= pxl_nxt;
        end
    end

endmodule

`default_nettype wire

/* logic/video_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster counters, sync and blanking
// vertical and line interrupts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "racer_video_settings.svh"

module video_timing (
    input  logic         clk,
    input  logic         rst,
    input  logic         pxl_cen,
    video_timing_if.src  tim,
    output logic         hs,
    output logic         vs,
    output logic         vint,
    output logic         line_intn
);

    racer_video_pkg::hpos_t hcnt;
    racer_video_pkg::vpos_t vcnt;
    racer_video_pkg::hpos_t h_nxt;
    racer_video_pkg::vpos_t v_nxt;
    logic                   lhbl_nxt;
    logic                   lvbl_nxt;
    logic                   irq_line;

    // counter values after the next pixel step
    always_comb begin
        h_nxt = hcnt + 8'd1;
        v_nxt = vcnt;
        if (hcnt == `RV_H_TOTAL - 1) begin
            h_nxt = '0;
            v_nxt = (vcnt == `RV_V_TOTAL - 1) ? '0 : vcnt + 8'd1;
        end
    end

    assign lhbl_nxt = h_nxt < `RV_H_VIS;
    assign lvbl_nxt = v_nxt < `RV_V_VIS;

    // lines 8, 16, 24 but not line 0
    assign irq_line = (vcnt != '0) && (vcnt < `RV_V_VIS) && ((vcnt % `RV_IRQ_STEP) == 0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            hcnt <= h_nxt;
            vcnt <= v_nxt;
        end
    end

    assign tim.hdump    = hcnt;
    assign tim.vdump    = vcnt;
    assign tim.pre_lhbl = hcnt < `RV_H_VIS;
    assign tim.pre_lvbl = vcnt < `RV_V_VIS;

    assign hs = (hcnt >= `RV_HS_START) && (hcnt < `RV_HS_END);
    assign vs = (vcnt >= `RV_VS_START) && (vcnt < `RV_VS_END);

    // edges are taken on the step itself, not one pixel late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint      <= 1'b0;
            line_intn <= 1'b1;
        end else begin
            vint <= pxl_cen && tim.pre_lvbl && !lvbl_nxt;
            if (pxl_cen) begin
                if (tim.pre_lhbl && !lhbl_nxt && irq_line) begin
                    line_intn <= 1'b0;
                end
                // released at the start of the next visible line
                if (!tim.pre_lhbl && lhbl_nxt) begin
                    line_intn <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/video_timing_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster position and pre-blanking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if;

    racer_video_pkg::hpos_t hdump;
    racer_video_pkg::vpos_t vdump;
    // high while visible
    logic                   pre_lhbl;
    logic                   pre_lvbl;

    modport src (
        output hdump, vdump, pre_lhbl, pre_lvbl
    );

    modport sink (
        input hdump, vdump, pre_lhbl, pre_lvbl
    );

endinterface

`default_nettype wire

/* test/racer_video_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on interrupts and
// blanking, bound into the video top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "racer_video_settings.svh"

module racer_video_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   vint,
    input logic                   line_intn,
    input logic                   lhbl,
    input logic                   lvbl,
    input racer_video_pkg::hpos_t hdump,
    input logic [4:0]             red,
    input logic [4:0]             green,
    input logic [4:0]             blue
);

    // failures seen so far
    int fail_cnt = 0;

    // vertical interrupt lasts one clock
    vint_single: assert property (@(posedge clk) disable iff (rst) vint |=> !vint)
        else begin
            fail_cnt++;
            $error("vint stayed high for more than one clock");
        end

    intn_in_hblank: assert property (@(posedge clk) disable iff (rst)
        !line_intn |-> hdump >= `RV_H_VIS)
        else begin
            fail_cnt++;
            $error("line_intn low outside horizontal blank");
        end

    // no colour outside the visible area
    black_in_blank: assert property (@(posedge clk) disable iff (rst)
        !(lhbl && lvbl) |-> (red == '0 && green == '0 && blue == '0))
        else begin
            fail_cnt++;
            $error("colour not zero during blanking");
        end

endmodule

bind racer_video racer_video_asserts u_asserts (.*);

`default_nettype wire

/* test/racer_video_golden.txt */
# W sel addr dswn data [count]   R sel addr word   P x y colour
# sel 0 is the road table, 1 the palette; addr, dswn, data, word, colour in hex
W 0 03 0 1111
W 0 03 2 0055
R 0 03 1155
W 0 03 1 2200
R 0 03 2255
W 1 05 0 1234
W 1 05 2 00CD
R 1 05 12CD
W 1 05 3 FFFF
R 1 05 12CD
W 0 00 0 0A18 8
W 0 08 0 0C14 8
W 0 10 0 061E 8
W 0 18 0 0C08 8
W 1 00 0 7C00
W 1 01 0 7C1F
W 1 02 0 03E0
W 1 03 0 001F
W 1 08 0 4210
W 1 09 0 A108
W 1 0A 0 7FFF
P 40 2 7C00
P 40 10 7C1F
P 5 18 03E0
P 30 26 001F
P 20 4 4210
P 20 2 2108
P 13 5 7C00
P 14 5 7FFF
P 35 20 7FFF
P 36 20 03E0
P 0 24 4210
P 19 27 7FFF
W 1 08 0 1111
P 20 4 1111
P 0 24 1111
P 20 2 2108

/* test/racer_video_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the video subsystem
// golden file stimulus, frame tracking
// and pixel, read-back and interrupt checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "racer_video_settings.svh"

module racer_video_tb;

    localparam int FRAME_CYC = `RV_H_TOTAL * `RV_V_TOTAL * 2;
    localparam int VIS_PIX   = `RV_H_VIS * `RV_V_VIS;

    logic                       clk;
    logic                       rst;
    logic                       pxl_cen;
    logic                       road_cs;
    logic                       pal_cs;
    racer_video_pkg::cpu_addr_t cpu_addr;
    racer_video_pkg::cpu_word_t cpu_dout;
    racer_video_pkg::byte_en_t  cpu_dswn;
    racer_video_pkg::cpu_word_t road_dout;
    racer_video_pkg::cpu_word_t pal_dout;
    logic                       hs, vs, lhbl, lvbl, vint, line_intn;
    racer_video_pkg::hpos_t     hdump;
    racer_video_pkg::vpos_t     vdump;
    logic [4:0]                 red, green, blue;

    // golden lines and the pixels still to be seen
    string       lines[$];
    int          exp_x[$];
    int          exp_y[$];
    logic [15:0] exp_col[$];

    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   cycle_limit = 0;
    // frame position, counted from the last lvbl rise
    int   frame_no = 0;
    int   vis_cnt = 0;
    int   vint_cnt = 0;
    int   intn_cnt = 0;
    int   chk_frame = -1;
    int   hits = 0;
    logic lvbl_q = 1'b0;
    logic intn_q = 1'b1;
    // raster position from the pxl_cen steps since reset
    int   ras_h = 0;
    int   ras_v = 0;

    racer_video uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    task automatic expect_value(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    // counters and sync windows against the raster position
    task automatic check_raster();
        expect_value("hdump", 16'(ras_h), {8'd0, hdump});
        expect_value("vdump", 16'(ras_v), {8'd0, vdump});
        expect_value($sformatf("hs at %0d,%0d", ras_h, ras_v),
                     16'(ras_h >= 52 && ras_h < 56), {15'd0, hs});
        expect_value($sformatf("vs at %0d,%0d", ras_h, ras_v),
                     16'(ras_v >= 34 && ras_v < 36), {15'd0, vs});
    endtask

    task automatic check_pixel(input int pos, input racer_video_pkg::rgb555_t col);
        int x;
        int y;
        x = pos % `RV_H_VIS;
        y = pos / `RV_H_VIS;
        foreach (exp_x[i]) begin
            if (exp_x[i] == x && exp_y[i] == y) begin
                hits++;
                expect_value($sformatf("pixel %0d,%0d in frame %0d", x, y, frame_no),
                             {1'b0, exp_col[i][14:0]}, {1'b0, col});
            end
        end
    endtask

    // one clock, then sample the outputs and drive pxl_cen
    task automatic tick();
        logic                     cen;
        racer_video_pkg::rgb555_t col;
        @(posedge clk);
        cen = pxl_cen;
        #1;
        col = {blue, green, red};
        if (cen) begin
            ras_h = (ras_h + 1) % 64;
            if (ras_h == 0)
                ras_v = (ras_v + 1) % 40;
        end
        check_raster();
        if (vint)
            vint_cnt++;
        if (intn_q && !line_intn) begin
            expect_value($sformatf("line interrupt %0d line", intn_cnt + 1),
                         16'(`RV_IRQ_STEP * (intn_cnt + 1)), {8'd0, vdump});
            intn_cnt++;
        end
        intn_q = line_intn;
        if (cen) begin
            if (lvbl && !lvbl_q) begin
                if (frame_no > 0) begin
                    expect_value($sformatf("frame %0d visible pixels", frame_no),
                                 16'(VIS_PIX), 16'(vis_cnt));
                    expect_value($sformatf("frame %0d vint pulses", frame_no), 16'd1,
                                 16'(vint_cnt));
                    expect_value($sformatf("frame %0d line interrupts", frame_no),
                                 16'(`RV_V_VIS / `RV_IRQ_STEP - 1), 16'(intn_cnt));
                end
                frame_no++;
                vis_cnt  = 0;
                vint_cnt = 0;
                intn_cnt = 0;
            end
            lvbl_q = lvbl;
            if (lhbl && lvbl) begin
                if (frame_no == chk_frame)
                    check_pixel(vis_cnt, col);
                vis_cnt++;
            end else begin
                expect_value("blanked colour", 16'd0, {1'b0, col});
            end
        end
        pxl_cen = ~pxl_cen;
    endtask

    // pending pixels are checked over the next whole frame
    task automatic check_frame();
        chk_frame = frame_no + 1;
        hits = 0;
        while (!(frame_no == chk_frame && vis_cnt == VIS_PIX)) begin
            tick();
        end
        chk_frame = -1;
        expect_value("expected pixels found", 16'(exp_x.size()), 16'(hits));
        exp_x.delete();
        exp_y.delete();
        exp_col.delete();
    endtask

    task automatic cpu_write(input int sel, input logic [15:0] addr, input logic [15:0] dswn,
                             input logic [15:0] data, input int count);
        for (int i = 0; i < count; i++) begin
            road_cs  = (sel == 0);
            pal_cs   = (sel == 1);
            cpu_addr = addr[4:0] + 5'(i);
            cpu_dswn = dswn[1:0];
            cpu_dout = data;
            tick();
        end
        road_cs  = 1'b0;
        pal_cs   = 1'b0;
        cpu_dswn = 2'b11;
    endtask

    // read data shows one clock after the address
    task automatic cpu_read(input int sel, input logic [15:0] addr, input logic [15:0] word);
        cpu_addr = addr[4:0];
        tick();
        expect_value($sformatf("%s read at 0x%0h", (sel == 0) ? "road" : "palette", addr),
                     word, (sel == 0) ? road_dout : pal_dout);
    endtask

    initial begin
        int          fd;
        int          n;
        byte         kind;
        int          sel;
        int          px;
        int          py;
        int          cnt;
        string       line;
        logic [15:0] f_addr;
        logic [15:0] f_dswn;
        logic [15:0] f_data;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        road_cs  = 1'b0;
        pal_cs   = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_dswn = 2'b11;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        expect_value("line_intn after reset", 16'd1, {15'd0, line_intn});
        fd = $fopen("test/racer_video_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("golden file test/racer_video_golden.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        cycle_limit = 3 * FRAME_CYC + lines.size() * `RV_H_TOTAL;
        foreach (lines[i]) begin
            kind = lines[i].getc(0);
            case (kind)
                "W": begin
                    n = $sscanf(lines[i], "%c %d %h %h %h %d", kind, sel, f_addr, f_dswn,
                                f_data, cnt);
                    // a write after pixel lines starts a new frame
                    if (exp_x.size() > 0)
                        check_frame();
                    cpu_write(sel, f_addr, f_dswn, f_data, (n == 6) ? cnt : 1);
                end
                "R": begin
                    n = $sscanf(lines[i], "%c %d %h %h", kind, sel, f_addr, f_data);
                    cpu_read(sel, f_addr, f_data);
                end
                "P": begin
                    n = $sscanf(lines[i], "%c %d %d %h", kind, px, py, f_data);
                    exp_x.push_back(px);
                    exp_y.push_back(py);
                    exp_col.push_back(f_data);
                end
                default: ;
            endcase
        end
        if (exp_x.size() > 0)
            check_frame();
        errors += uut.u_asserts.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 uut.u_asserts.fail_cnt);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
